//--- source/sdram_pkg.sv
/*
 * shared SDRAM controller definitions
 * command, slot-kind and sequencer-state enums, CAS latency, mode bits, refresh idle count
 */
`default_nettype none

package sdram_pkg;

    // {ncs, nras, ncas, nwe}
    typedef enum logic [3:0] {
        LOAD_MODE   = 4'b0000,
        AUTOREFRESH = 4'b0001,
        PRECHARGE   = 4'b0010,
        ACTIVATE    = 4'b0011,
        WRITE       = 4'b0100,
        READ        = 4'b0101,
        NOP         = 4'b0111,
        INHIBIT     = 4'b1000
    } sdram_cmd_e;

    typedef enum logic [1:0] {
        SLOT_READ,
        SLOT_WRITE,
        SLOT_REFRESH,
        SLOT_MODE
    } slot_kind_e;

    typedef enum logic [3:0] {
        INIT_WAIT, INIT_PRE, INIT_REF, INIT_MODE, INIT_PRE2, // power-up
        IDLE, ACT, RW, WAIT1, CAP1, CAP2                     // slots
    } seq_state_e;

    localparam int CAS_LAT = 2;

    // single-location writes, sequential, burst field left at 0 (one word)
    localparam logic [12:0] MODE_BASE = {3'b000, 1'b1, 2'b00, 3'(CAS_LAT), 1'b0, 3'b000};

    localparam int REFRESH_IDLE = 3; // idle cycles before a refresh slot

endpackage

`default_nettype wire

//--- source/sdram_req_sel.sv
/*
 * request selection stage
 * loader strobe capture, downloading edge detect, idle refresh counter,
 * slot priority and game ack
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_req_sel #(
    parameter int ADDR_W = 22
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       read_req,    // level, held until ack
    input  wire  [ADDR_W-1:0]         sdram_addr,
    input  wire                       refresh_en,
    input  wire                       downloading,
    input  wire                       prog_we,     // one-cycle strobe
    input  wire  [ADDR_W-1:0]         prog_addr,
    input  wire  [7:0]                prog_data,
    input  wire  [1:0]                prog_mask,
    input  wire                       seq_idle,
    input  wire                       init_busy,
    output logic                      sdram_ack,
    output logic                      slot_go,
    output sdram_pkg::slot_kind_e     slot_kind,
    output logic [ADDR_W-1:0]         slot_addr,
    output logic [7:0]                slot_data,
    output logic [1:0]                slot_mask
);

    localparam int RC_W = $clog2(sdram_pkg::REFRESH_IDLE + 1);

    logic                  dl_last;     // downloading one cycle ago
    logic                  mode_pend;
    logic                  mode_burst;  // 1 = burst of two
    logic                  wr_pend;
    logic [ADDR_W-1:0]     wr_addr;
    logic [7:0]            wr_data;
    logic [1:0]            wr_mask;
    logic [RC_W-1:0]       idle_cnt;
    logic                  prog_hit;
    logic                  can_go;
    logic                  want_read;
    logic                  want_ref;
    logic                  grant;
    sdram_pkg::slot_kind_e grant_kind;

    assign prog_hit  = prog_we && downloading && !init_busy;
    assign can_go    = seq_idle && !slot_go && !init_busy; // slot_go covers the idle cycle it leaves
    // a falling downloading edge must reprogram the burst before any game access
    assign want_read = read_req && !downloading && !dl_last;
    assign want_ref  = refresh_en && !downloading;

    // priority: mode, load write, game read, refresh
    always_comb begin
        grant      = 1'b0;
        grant_kind = sdram_pkg::SLOT_REFRESH;
        if (can_go) begin
            if (mode_pend) begin
                grant      = 1'b1;
                grant_kind = sdram_pkg::SLOT_MODE;
            end else if (wr_pend) begin
                grant      = 1'b1;
                grant_kind = sdram_pkg::SLOT_WRITE;
            end else if (want_read) begin
                grant      = 1'b1;
                grant_kind = sdram_pkg::SLOT_READ;
            end else if (want_ref && idle_cnt == RC_W'(sdram_pkg::REFRESH_IDLE)) begin
                grant      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_hit) begin  // no back-pressure, loader keeps its spacing
            wr_addr <= prog_addr;
            wr_data <= prog_data;
            wr_mask <= prog_mask;
        end
        if (grant) begin
            slot_data <= wr_data;
            slot_mask <= wr_mask;
            if (grant_kind == sdram_pkg::SLOT_WRITE)
                slot_addr <= wr_addr;
            else if (grant_kind == sdram_pkg::SLOT_READ)
                slot_addr <= sdram_addr;
            else
                slot_addr <= ADDR_W'(mode_burst); // bit 0 carries the new burst length
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dl_last    <= 1'b0;
            mode_pend  <= 1'b0;
            mode_burst <= 1'b1;
            wr_pend    <= 1'b0;
            idle_cnt   <= '0;
            slot_go    <= 1'b0;
            slot_kind  <= sdram_pkg::SLOT_REFRESH;
            sdram_ack  <= 1'b0;
        end else begin
            dl_last   <= downloading;
            slot_go   <= grant;
            sdram_ack <= slot_go && slot_kind == sdram_pkg::SLOT_READ; // one cycle after go
            if (grant)
                slot_kind <= grant_kind;
            if (grant && grant_kind == sdram_pkg::SLOT_MODE)
                mode_pend <= 1'b0;
            if (grant && grant_kind == sdram_pkg::SLOT_WRITE)
                wr_pend <= 1'b0;
            // set after clear, a new event wins over the grant of an old one
            if (downloading != dl_last) begin
                mode_pend  <= 1'b1;
                mode_burst <= !downloading; // burst 1 while loading
            end
            if (prog_hit)
                wr_pend <= 1'b1;
            // consecutive idle cycles with refresh allowed
            if (can_go && want_ref && !grant)
                idle_cnt <= idle_cnt + 1'b1;
            else
                idle_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_cmd_seq.sv
/*
 * command sequencing stage
 * power-up sequence, slot FSM, command/address/mask/write-data pins,
 * capture pulses for the read stage
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_seq #(
    parameter int ADDR_W    = 22,
    parameter int INIT_WAIT = 5000
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         slot_go,
    input  wire sdram_pkg::slot_kind_e  slot_kind,  // held by stage 1 for the whole slot
    input  wire  [ADDR_W-1:0]           slot_addr,
    input  wire  [7:0]                  slot_data,
    input  wire  [1:0]                  slot_mask,
    output logic                        seq_idle,
    output logic                        init_busy,
    output logic                        burst_two,
    output sdram_pkg::sdram_cmd_e       sdram_cmd,
    output logic [12:0]                 sdram_a,
    output logic [1:0]                  sdram_dqm,  // {dqmh, dqml}
    output logic [15:0]                 dq_out,
    output logic                        dq_oe,
    output logic                        cap_first,
    output logic                        cap_second
);

    // power-up step lengths, command cycle included (20 in total)
    localparam int T_PRE  = 3;
    localparam int T_REF  = 11;  // trfc
    localparam int T_MODE = 3;
    localparam int T_PRE2 = 3;

    // NOP cycles after the slot command
    localparam int WR_NOPS   = 3;  // write recovery + auto precharge
    localparam int REF_NOPS  = 3;
    localparam int MODE_NOPS = 2;

    localparam int CNT_W = $clog2(INIT_WAIT + 16);

    sdram_pkg::seq_state_e state;
    logic [CNT_W-1:0]      wait_cnt;
    logic                  is_write;

    assign seq_idle = (state == sdram_pkg::IDLE);
    assign is_write = (slot_kind == sdram_pkg::SLOT_WRITE);

    // write data, byte copied to both halves; mask picks the lane
    always_ff @(posedge clk) begin
        if (state == sdram_pkg::ACT && is_write)
            dq_out <= {slot_data, slot_data};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= sdram_pkg::INIT_WAIT;
            wait_cnt   <= CNT_W'(INIT_WAIT - 1);
            init_busy  <= 1'b1;
            burst_two  <= 1'b0;
            sdram_cmd  <= sdram_pkg::NOP;
            sdram_a    <= '0;
            sdram_dqm  <= '0;
            dq_oe      <= 1'b0;
            cap_first  <= 1'b0;
            cap_second <= 1'b0;
        end else begin
            sdram_cmd  <= sdram_pkg::NOP; // default every cycle
            dq_oe      <= 1'b0;
            cap_first  <= 1'b0;
            cap_second <= 1'b0;
            case (state)
                sdram_pkg::INIT_WAIT, sdram_pkg::INIT_PRE, sdram_pkg::INIT_REF,
                sdram_pkg::INIT_MODE, sdram_pkg::INIT_PRE2: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        case (state)
                            sdram_pkg::INIT_WAIT: begin
                                state     <= sdram_pkg::INIT_PRE;
                                sdram_cmd <= sdram_pkg::PRECHARGE;
                                sdram_a   <= 13'h0400; // a10, all banks
                                wait_cnt  <= CNT_W'(T_PRE - 1);
                            end
                            sdram_pkg::INIT_PRE: begin
                                state     <= sdram_pkg::INIT_REF;
                                sdram_cmd <= sdram_pkg::AUTOREFRESH;
                                wait_cnt  <= CNT_W'(T_REF - 1);
                            end
                            sdram_pkg::INIT_REF: begin
                                state     <= sdram_pkg::INIT_MODE;
                                sdram_cmd <= sdram_pkg::LOAD_MODE;
                                sdram_a   <= sdram_pkg::MODE_BASE | 13'd1; // burst 2
                                burst_two <= 1'b1;
                                wait_cnt  <= CNT_W'(T_MODE - 1);
                            end
                            sdram_pkg::INIT_MODE: begin
                                state     <= sdram_pkg::INIT_PRE2;
                                sdram_cmd <= sdram_pkg::PRECHARGE;
                                sdram_a   <= 13'h0400;
                                wait_cnt  <= CNT_W'(T_PRE2 - 1);
                            end
                            default: begin // end of INIT_PRE2
                                state     <= sdram_pkg::IDLE;
                                init_busy <= 1'b0;
                            end
                        endcase
                    end
                end
                sdram_pkg::IDLE: begin
                    if (slot_go) begin
                        case (slot_kind)
                            sdram_pkg::SLOT_MODE: begin
                                sdram_cmd <= sdram_pkg::LOAD_MODE;
                                sdram_a   <= sdram_pkg::MODE_BASE | {12'd0, slot_addr[0]};
                                burst_two <= slot_addr[0];
                                wait_cnt  <= CNT_W'(MODE_NOPS - 1);
                                state     <= sdram_pkg::WAIT1;
                            end
                            sdram_pkg::SLOT_REFRESH: begin
                                sdram_cmd <= sdram_pkg::AUTOREFRESH;
                                wait_cnt  <= CNT_W'(REF_NOPS - 1);
                                state     <= sdram_pkg::WAIT1;
                            end
                            default: begin  // read or write opens the row
                                sdram_cmd <= sdram_pkg::ACTIVATE;
                                sdram_a   <= slot_addr[9 +: 13];
                                state     <= sdram_pkg::ACT;
                            end
                        endcase
                    end
                end
                sdram_pkg::ACT: begin
                    // column command, a10 set for auto precharge
                    sdram_a <= {2'b00, 1'b1, 1'b0, slot_addr[8:0]};
                    state   <= sdram_pkg::RW;
                    if (is_write) begin
                        sdram_cmd <= sdram_pkg::WRITE;
                        sdram_dqm <= slot_mask;  // set bit keeps the byte
                        dq_oe     <= 1'b1;
                        wait_cnt  <= CNT_W'(WR_NOPS - 1);
                    end else begin
                        sdram_cmd <= sdram_pkg::READ;
                        sdram_dqm <= 2'b00;
                        wait_cnt  <= CNT_W'(sdram_pkg::CAS_LAT - 2); // cas delay before capture
                    end
                end
                sdram_pkg::RW: begin
                    sdram_dqm <= 2'b00;
                    state     <= sdram_pkg::WAIT1;
                end
                sdram_pkg::WAIT1: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else if (slot_kind == sdram_pkg::SLOT_READ) begin
                        cap_first <= 1'b1;  // first word on dq next cycle
                        state     <= sdram_pkg::CAP1;
                    end else begin
                        state <= sdram_pkg::IDLE;
                    end
                end
                sdram_pkg::CAP1: begin
                    cap_second <= burst_two; // no second word with burst 1
                    state      <= sdram_pkg::CAP2;
                end
                default: begin  // CAP2
                    state <= sdram_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_rd_capture.sv
/*
 * read capture stage
 * samples dq on the capture pulses, builds the 32-bit word, data_rdy pulse
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_rd_capture (
    input  wire         clk,
    input  wire         rst,
    input  wire  [15:0] dq_in,
    input  wire         cap_first,   // dq holds word 0
    input  wire         cap_second,  // dq holds word 1
    output logic [31:0] data_read,
    output logic        data_rdy
);

    logic [15:0] first_q;  // low half waiting for its partner

    // data path, output only changes together with data_rdy
    always_ff @(posedge clk) begin
        if (cap_first)
            first_q <= dq_in;
        if (cap_second)
            data_read <= {dq_in, first_q}; // second word in the high half
    end

    // pulse lands on the cycle after the second sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            data_rdy <= 1'b0;
        else
            data_rdy <= cap_second;
    end

endmodule

`default_nettype wire

//--- source/sdram_ctrl_top.sv
/*
 * SDRAM controller top level
 * request selection, command sequencing and read capture in pipeline order
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top #(
    parameter int INIT_WAIT = 5000,  // power-up wait in cycles
    parameter int ADDR_W    = 22
) (
    input  wire                        clk,
    input  wire                        rst,
    // game
    input  wire                        read_req,
    input  wire  [ADDR_W-1:0]          sdram_addr,
    input  wire                        refresh_en,
    output wire  [31:0]                data_read,
    output wire                        data_rdy,
    output wire                        sdram_ack,
    // loader
    input  wire                        downloading,
    input  wire                        prog_we,
    input  wire  [ADDR_W-1:0]          prog_addr,
    input  wire  [7:0]                 prog_data,
    input  wire  [1:0]                 prog_mask,
    output wire                        init_busy,
    // SDRAM pins, dq split into in/out/enable
    output wire sdram_pkg::sdram_cmd_e sdram_cmd,
    output wire  [12:0]                sdram_a,
    output wire  [1:0]                 sdram_dqm,
    output wire  [15:0]                dq_out,
    output wire                        dq_oe,
    input  wire  [15:0]                dq_in
);

    wire                        seq_idle;
    wire                        slot_go;
    wire sdram_pkg::slot_kind_e slot_kind;
    wire [ADDR_W-1:0]           slot_addr;
    wire [7:0]                  slot_data;
    wire [1:0]                  slot_mask;
    wire                        cap_first;
    wire                        cap_second;

    sdram_req_sel #(
        .ADDR_W      (ADDR_W)
    ) u_req_sel (
        .clk         (clk),
        .rst         (rst),
        .read_req    (read_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .downloading (downloading),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .seq_idle    (seq_idle),
        .init_busy   (init_busy),
        .sdram_ack   (sdram_ack),
        .slot_go     (slot_go),
        .slot_kind   (slot_kind),
        .slot_addr   (slot_addr),
        .slot_data   (slot_data),
        .slot_mask   (slot_mask)
    );

    sdram_cmd_seq #(
        .ADDR_W     (ADDR_W),
        .INIT_WAIT  (INIT_WAIT)
    ) u_cmd_seq (
        .clk        (clk),
        .rst        (rst),
        .slot_go    (slot_go),
        .slot_kind  (slot_kind),
        .slot_addr  (slot_addr),
        .slot_data  (slot_data),
        .slot_mask  (slot_mask),
        .seq_idle   (seq_idle),
        .init_busy  (init_busy),
        .burst_two  (),           // current burst length, used inside the sequencer
        .sdram_cmd  (sdram_cmd),
        .sdram_a    (sdram_a),
        .sdram_dqm  (sdram_dqm),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .cap_first  (cap_first),
        .cap_second (cap_second)
    );

    sdram_rd_capture u_rd_capture (
        .clk        (clk),
        .rst        (rst),
        .dq_in      (dq_in),
        .cap_first  (cap_first),
        .cap_second (cap_second),
        .data_read  (data_read),
        .data_rdy   (data_rdy)
    );

endmodule

`default_nettype wire

//--- sim/sdram_model.sv
/*
 * behavioural SDRAM, 1024 words of 16 bits
 * CAS latency 2, burst 1 or 2, byte masks, refresh counter
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                        clk,
    input  wire sdram_pkg::sdram_cmd_e cmd,
    input  wire  [12:0]                a,
    input  wire  [1:0]                 dqm,    // set bit keeps the byte
    input  wire  [15:0]                dq_wr,
    input  wire                        dq_oe,
    output logic [15:0]                dq_rd
);

    logic [15:0] mem [1024];
    logic        row_lsb;     // row bit 0 picks the upper half of the array
    logic        burst_two;
    logic [8:0]  rd_col;
    logic [1:0]  rd_step;     // 1 = first word next, 2 = second word next
    int          ref_cnt;

    initial begin
        logic [9:0] k;
        row_lsb   = 1'b0;
        burst_two = 1'b0;
        rd_col    = '0;
        rd_step   = '0;
        ref_cnt   = 0;
        dq_rd     = '0;
        for (int i = 0; i < 1024; i++) begin
            k      = 10'(i);
            mem[i] = {k[5:0], k} ^ 16'hc3a5; // fill from the whole address
        end
    end

    always @(posedge clk) begin
        case (cmd)
            sdram_pkg::ACTIVATE:    row_lsb <= a[0];
            sdram_pkg::READ: begin
                rd_col  <= a[8:0];
                rd_step <= 2'd1;  // word 0 driven one cycle later, sampled at cl 2
            end
            sdram_pkg::WRITE: begin
                if (dq_oe && !dqm[0])
                    mem[{row_lsb, a[8:0]}][7:0] <= dq_wr[7:0];
                if (dq_oe && !dqm[1])
                    mem[{row_lsb, a[8:0]}][15:8] <= dq_wr[15:8];
            end
            sdram_pkg::LOAD_MODE:   burst_two <= (a[2:0] == 3'd1);
            sdram_pkg::AUTOREFRESH: ref_cnt <= ref_cnt + 1;
            default: ;
        endcase
        if (rd_step == 2'd1) begin
            dq_rd   <= mem[{row_lsb, rd_col}];
            rd_step <= burst_two ? 2'd2 : 2'd0;
        end else if (rd_step == 2'd2) begin
            dq_rd   <= mem[{row_lsb, rd_col ^ 9'd1}]; // burst of two wraps within the pair
            rd_step <= 2'd0;
        end
    end

endmodule

`default_nettype wire

//--- sim/sdram_props.sv
/*
 * command and pulse rules of the sequencer, bound into sdram_cmd_seq
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_props (
    input wire                        clk,
    input wire                        rst,
    input wire sdram_pkg::sdram_cmd_e sdram_cmd,
    input wire                        dq_oe,
    input wire                        cap_second,  // data_rdy is its registered copy
    input wire                        slot_go,
    input wire                        seq_idle
);

    a_write_after_act: assert property (@(posedge clk) disable iff (rst)
        sdram_cmd == sdram_pkg::WRITE |-> $past(sdram_cmd) == sdram_pkg::ACTIVATE)
        else $error("WRITE not preceded by ACTIVATE");

    a_oe_in_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> sdram_cmd == sdram_pkg::WRITE)
        else $error("dq_oe outside the WRITE cycle");

    a_rdy_single: assert property (@(posedge clk) disable iff (rst)
        cap_second |=> !cap_second)
        else $error("read ready pulse longer than one cycle");

    a_go_when_idle: assert property (@(posedge clk) disable iff (rst)
        slot_go |-> seq_idle)
        else $error("slot_go while the sequencer is busy");

endmodule

bind sdram_cmd_seq sdram_props u_props (
    .clk        (clk),
    .rst        (rst),
    .sdram_cmd  (sdram_cmd),
    .dq_oe      (dq_oe),
    .cap_second (cap_second),
    .slot_go    (slot_go),
    .seq_idle   (seq_idle)
);

`default_nettype wire

//--- sim/tb_sdram.sv
/*
 * testbench for the SDRAM controller
 * clock, reset, stimulus table, shadow memory, pin monitors and checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram;

    localparam int INIT_W = 40;
    localparam int N_STIM = 13;
    localparam int LIMIT  = N_STIM * 12 + INIT_W + 200; // cycles

    typedef enum logic [1:0] {K_WRITE, K_DL_END, K_READ} kind_e;
    typedef struct packed {
        kind_e      kind;
        logic [9:0] addr;
        logic [1:0] mask;  // {high, low}, set bit keeps the byte
    } stim_t;

    localparam stim_t STIM [N_STIM] = '{
        '{K_WRITE, 10'h010, 2'b00}, '{K_WRITE, 10'h011, 2'b00},
        '{K_WRITE, 10'h011, 2'b01}, '{K_WRITE, 10'h124, 2'b10},
        '{K_WRITE, 10'h125, 2'b00}, '{K_WRITE, 10'h3ff, 2'b00},
        '{K_WRITE, 10'h3fe, 2'b11}, '{K_DL_END, 10'h000, 2'b00},
        '{K_READ, 10'h010, 2'b00}, '{K_READ, 10'h011, 2'b00},
        '{K_READ, 10'h124, 2'b00}, '{K_READ, 10'h3ff, 2'b00},
        '{K_READ, 10'h200, 2'b00}  // untouched fill
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  read_req;
    logic [21:0]           sdram_addr;
    logic                  refresh_en;
    logic                  downloading;
    logic                  prog_we;
    logic [21:0]           prog_addr;
    logic [7:0]            prog_data;
    logic [1:0]            prog_mask;
    logic [31:0]           data_read;
    logic                  data_rdy;
    logic                  sdram_ack;
    logic                  init_busy;
    sdram_pkg::sdram_cmd_e sdram_cmd;
    logic [12:0]           sdram_a;
    logic [1:0]            sdram_dqm;
    logic [15:0]           dq_out;
    logic                  dq_oe;
    logic [15:0]           dq_in;

    logic [15:0]           shadow [1024];
    logic [31:0]           rng = 32'hc237_bbcd;
    sdram_pkg::sdram_cmd_e init_cmds [$];
    logic [12:0]           init_a [$];
    int                    cycles       = 0;
    int                    init_len     = 0;
    int                    ack_cnt      = 0;
    int                    rdy_cnt      = 0;
    int                    dl_hist      = 0;
    int                    ref_seen     = 0;
    int                    bad_ref      = 0;
    int                    mode_errs    = 0;
    int                    read_errs    = 0;
    int                    reads        = 0;
    int                    errors       = 0;
    int                    tests        = 0;
    int                    tests_failed = 0;
    logic                  dl_ended     = 1'b0;
    logic                  mode_after   = 1'b0;

    always #2 clk = ~clk;

    sdram_ctrl_top #(.INIT_WAIT(INIT_W), .ADDR_W(22)) UUT (
        .clk(clk), .rst(rst), .read_req(read_req), .sdram_addr(sdram_addr),
        .refresh_en(refresh_en), .data_read(data_read), .data_rdy(data_rdy),
        .sdram_ack(sdram_ack), .downloading(downloading), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .init_busy(init_busy), .sdram_cmd(sdram_cmd), .sdram_a(sdram_a),
        .sdram_dqm(sdram_dqm), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    sdram_model u_model (
        .clk(clk), .cmd(sdram_cmd), .a(sdram_a), .dqm(sdram_dqm),
        .dq_wr(dq_out), .dq_oe(dq_oe), .dq_rd(dq_in)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // byte lands in each lane whose mask bit is clear
    function automatic logic [15:0] masked_word(input logic [15:0] old,
                                                input logic [7:0] b, input logic [1:0] m);
        return {m[1] ? old[15:8] : b, m[0] ? old[7:0] : b};
    endfunction

    // pin monitors, sampled on the rising edge
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst && init_busy) begin
            init_len <= init_len + 1;
            if (sdram_cmd != sdram_pkg::NOP) begin
                init_cmds.push_back(sdram_cmd);
                init_a.push_back(sdram_a);
            end
        end
        if (sdram_ack) ack_cnt <= ack_cnt + 1;
        if (data_rdy)  rdy_cnt <= rdy_cnt + 1;
        dl_hist <= downloading ? ((dl_hist < 3) ? dl_hist + 1 : 3) : 0;
        if (!init_busy && sdram_cmd == sdram_pkg::AUTOREFRESH) begin
            ref_seen <= ref_seen + 1;
            if (dl_hist >= 3) begin  // settled download, grant could not be in flight
                $display("refresh issued at %0t while downloading", $time);
                bad_ref <= bad_ref + 1;
            end
        end
        if (dl_ended && sdram_cmd == sdram_pkg::LOAD_MODE && sdram_a[2:0] == 3'd1)
            mode_after <= 1'b1;
        if (dl_ended && !mode_after && sdram_cmd == sdram_pkg::ACTIVATE) begin
            $display("game ACTIVATE at %0t before the burst 2 mode load", $time);
            mode_errs <= mode_errs + 1;
        end
        if (cycles >= LIMIT) begin
            $display("timeout: run passed the limit of %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic report(input string name, input int nerr);
        tests++;
        errors += nerr;
        if (nerr != 0) tests_failed++;
        $display("test %s: %s (%0d errors)", name, (nerr == 0) ? "ok" : "FAILED", nerr);
    endtask

    task automatic load_write(input logic [9:0] addr, input logic [1:0] mask);
        rng = xorshift(rng);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= 22'(addr);
        prog_data <= rng[7:0];
        prog_mask <= mask;
        @(posedge clk);
        prog_we <= 1'b0;
        shadow[addr] = masked_word(shadow[addr], rng[7:0], mask);
        repeat (7) @(posedge clk);  // loader spacing
    endtask

    task automatic read_game(input logic [9:0] addr);
        logic [31:0] exp;
        int lat;
        exp = {shadow[addr ^ 10'd1], shadow[addr]}; // second word in the high half
        @(posedge clk);
        read_req   <= 1'b1;
        sdram_addr <= 22'(addr);
        @(posedge clk);
        while (!sdram_ack) @(posedge clk);
        read_req <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_rdy);
        reads++;
        if (lat != 5) begin
            $display("ERR %0t ack_to_rdy got %0d exp %0d", $time, lat, 5);
            read_errs++;
        end
        if (data_read != exp) begin
            $display("ERR %0t data_read got %h exp %h", $time, data_read, exp);
            read_errs++;
        end
    endtask

    initial begin
        int nerr;
        int ref0;
        int mref0;
        rst         = 1'b1;
        read_req    = 1'b0;
        sdram_addr  = '0;
        refresh_en  = 1'b0;
        downloading = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        prog_mask   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // power-up sequence
        while (init_busy) @(posedge clk);
        @(posedge clk);
        nerr = 0;
        if (init_len != INIT_W + 20) begin
            $display("ERR %0t init_busy_cycles got %0d exp %0d", $time, init_len, INIT_W + 20);
            nerr++;
        end
        if (init_cmds.size() != 4) begin
            $display("power-up showed %0d commands instead of 4", init_cmds.size());
            nerr++;
        end else if (init_cmds[0] != sdram_pkg::PRECHARGE || init_cmds[1] != sdram_pkg::AUTOREFRESH
                     || init_cmds[2] != sdram_pkg::LOAD_MODE
                     || init_cmds[3] != sdram_pkg::PRECHARGE) begin
            $display("power-up commands came in the wrong order");
            nerr++;
        end else if (init_a[2][2:0] != 3'd1) begin
            $display("ERR %0t mode_burst got %h exp %h", $time, init_a[2][2:0], 3'd1);
            nerr++;
        end
        report("power_up", nerr);

        for (int i = 0; i < 1024; i++) shadow[i] = u_model.mem[i];
        refresh_en  <= 1'b1;
        downloading <= 1'b1;
        repeat (10) @(posedge clk);  // burst 1 mode slot

        for (int n = 0; n < N_STIM; n++) begin
            case (STIM[n].kind)
                K_WRITE: load_write(STIM[n].addr, STIM[n].mask);
                K_DL_END: begin
                    nerr = 0;
                    for (int i = 0; i < 1024; i++) begin
                        if (u_model.mem[i] != shadow[i]) begin
                            $display("ERR %0t mem[%0d] got %h exp %h", $time, i,
                                     u_model.mem[i], shadow[i]);
                            nerr++;
                        end
                    end
                    report("masked_writes", nerr);
                    @(posedge clk);
                    downloading <= 1'b0;
                    dl_ended    <= 1'b1;
                end
                default: read_game(STIM[n].addr);
            endcase
        end
        report("mode_after_download", mode_errs + (mode_after ? 0 : 1));
        @(posedge clk);  // pulse counters take in the last data_rdy
        if (ack_cnt != reads || rdy_cnt != reads) begin
            $display("%0d reads saw %0d acks and %0d ready pulses", reads, ack_cnt, rdy_cnt);
            read_errs++;
        end
        report("game_reads", read_errs);

        // idle with refresh allowed
        ref0  = ref_seen;
        mref0 = u_model.ref_cnt;
        repeat (40) @(posedge clk);
        nerr = bad_ref;
        if (ref_seen <= ref0 || u_model.ref_cnt <= mref0) begin
            $display("no AUTOREFRESH while idle with refresh_en high");
            nerr++;
        end
        report("refresh", nerr);

        $display("tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/sdram_pkg.sv
source/sdram_req_sel.sv
source/sdram_cmd_seq.sv
source/sdram_rd_capture.sv
source/sdram_ctrl_top.sv
sim/sdram_model.sv
sim/sdram_props.sv
sim/tb_sdram.sv

//--- run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_sdram -o sim_tb_sdram

./obj_dir/sim_tb_sdram > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
